// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary -Wno-fatal --top-module tb_rda -f project.f

run: build
	./obj_dir/Vtb_rda > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "=== FAIL ===" sim.log; then exit 1; fi

lint:
	verilator --lint-only -Wall --top-module rda_top \
		design/rda_pkg.sv design/rda_prefix_stage.sv design/rda_core.sv \
		design/rda_result_buffer.sv design/rda_top.sv

clean:
	rm -rf obj_dir sim.log

// File: design/rda_core.sv
// Adder core with KGP encoding, pipelined doubling network and sum formation
`timescale 1ns/1ps

module rda_core (
	input  logic              clk,
	input  logic              rst,
	input  rda_pkg::add_req_t req,
	input  logic              req_valid,
	output rda_pkg::add_rsp_t rsp,
	output logic              rsp_valid
);
	import rda_pkg::*;

	kgp_t [NUM_SYMBOLS-1:0] enc_sym;
	prefix_bus_t            enc_bus;
	prefix_bus_t            stage_bus [PREFIX_STAGES+1];

	logic [DATA_WIDTH-1:0]  carry;
	kgp_t                   top_sym;
	logic                   carry_out;

	// Operand bit pairs to KGP with the carry-in as kill or generate
	always_comb begin
		enc_sym[0] = req.cin ? KGP_GEN : KGP_KILL;
		for (int i = 0; i < DATA_WIDTH; i++) begin
			if (req.a[i] ^ req.b[i])
				enc_sym[i+1] = KGP_PROP;
			else if (req.a[i])
				enc_sym[i+1] = KGP_GEN;
			else
				enc_sym[i+1] = KGP_KILL;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			enc_bus.valid <= 1'b0;
		else
			enc_bus.valid <= req_valid;
		enc_bus.sym <= enc_sym;
		enc_bus.prop <= req.a ^ req.b;
	end

	assign stage_bus[0] = enc_bus;

	// Distances 1/2, 4/8, 16/32
	for (genvar s = 0; s < PREFIX_STAGES; s++) begin : g_stage
		rda_prefix_stage #(
			.FIRST_DIST(1 << (2 * s))
		) u_stage (
			.clk     (clk),
			.rst     (rst),
			.bus_in  (stage_bus[s]),
			.bus_out (stage_bus[s+1])
		);
	end

	// Symbols 0..63 are resolved, so their generate bits are the carries
	always_comb begin
		for (int i = 0; i < DATA_WIDTH; i++) begin
			carry[i] = stage_bus[PREFIX_STAGES].sym[i][1];
		end
	end

	// Symbol 64 reaches back to symbol 1 only, so fold in the carry-in
	assign top_sym = kgp_combine(stage_bus[PREFIX_STAGES].sym[DATA_WIDTH],
		stage_bus[PREFIX_STAGES].sym[0]);
	assign carry_out = top_sym[1];

	always_ff @(posedge clk) begin
		if (rst)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= stage_bus[PREFIX_STAGES].valid;
		rsp.sum <= {carry_out, stage_bus[PREFIX_STAGES].prop ^ carry};
	end

	// Fixed pipeline with no stalls and no drops
	a_core_latency: assert property (@(posedge clk) disable iff (rst)
		rsp_valid == $past(req_valid, CORE_LATENCY))
		else $error("core valid does not follow request by CORE_LATENCY");

endmodule

// File: design/rda_pkg.sv
// Recursive doubling adder package with widths, KGP codes and pipeline structs
package rda_pkg;

	// Operand and result widths
	localparam int DATA_WIDTH = 64;
	localparam int SUM_WIDTH = DATA_WIDTH + 1;

	// Carry-in is symbol 0 and operand bit i is symbol i+1
	localparam int NUM_SYMBOLS = DATA_WIDTH + 1;

	// Distances 1, 2, 4, 8, 16, 32 with two levels per stage
	localparam int PREFIX_LEVELS = 6;
	localparam int PREFIX_STAGES = PREFIX_LEVELS / 2;

	// Encode register, prefix stages, sum register
	localparam int CORE_LATENCY = PREFIX_STAGES + 2;

	// Result buffer and output credits
	localparam int RESULT_DEPTH = 8;
	localparam int OUT_CREDIT_INIT = 4;
	localparam int PTR_WIDTH = $clog2(RESULT_DEPTH);
	localparam int COUNT_WIDTH = $clog2(RESULT_DEPTH + 1);
	localparam int CREDIT_WIDTH = $clog2(OUT_CREDIT_INIT + 1);

	// KGP symbol with the generate bit on top
	typedef logic [1:0] kgp_t;

	localparam kgp_t KGP_KILL = 2'b00;
	localparam kgp_t KGP_PROP = 2'b01;
	localparam kgp_t KGP_GEN = 2'b11;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] a;
		logic [DATA_WIDTH-1:0] b;
		logic                  cin;
	} add_req_t;

	typedef struct packed {
		logic                         valid;
		kgp_t [NUM_SYMBOLS-1:0]       sym;
		logic [DATA_WIDTH-1:0]        prop;
	} prefix_bus_t;

	typedef struct packed {
		logic [SUM_WIDTH-1:0] sum;
	} add_rsp_t;

	// Kill or generate above wins and propagate takes the lower symbol
	function automatic kgp_t kgp_combine(kgp_t hi, kgp_t lo);
		kgp_t res;
		if (hi[1] != hi[0])
			res = lo;
		else
			res = hi;
		return res;
	endfunction

endpackage

// File: design/rda_prefix_stage.sv
// KGP prefix stage with two doubling levels and an output register
`timescale 1ns/1ps

module rda_prefix_stage #(
	parameter int FIRST_DIST = 1
) (
	input  logic                 clk,
	input  logic                 rst,
	input  rda_pkg::prefix_bus_t bus_in,
	output rda_pkg::prefix_bus_t bus_out
);
	import rda_pkg::*;

	localparam int SECOND_DIST = 2 * FIRST_DIST;

	kgp_t [NUM_SYMBOLS-1:0] lvl1;
	kgp_t [NUM_SYMBOLS-1:0] lvl2;

	// First level at FIRST_DIST
	for (genvar i = 0; i < NUM_SYMBOLS; i++) begin : g_lvl1
		if (i >= FIRST_DIST) begin : g_comb
			assign lvl1[i] = kgp_combine(bus_in.sym[i], bus_in.sym[i-FIRST_DIST]);
		end else begin : g_pass
			assign lvl1[i] = bus_in.sym[i];
		end
	end

	// Second level at twice the distance
	for (genvar i = 0; i < NUM_SYMBOLS; i++) begin : g_lvl2
		if (i >= SECOND_DIST) begin : g_comb
			assign lvl2[i] = kgp_combine(lvl1[i], lvl1[i-SECOND_DIST]);
		end else begin : g_pass
			assign lvl2[i] = lvl1[i];
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			bus_out.valid <= 1'b0;
		else
			bus_out.valid <= bus_in.valid;
		bus_out.sym <= lvl2;
		bus_out.prop <= bus_in.prop;
	end

endmodule

// File: design/rda_result_buffer.sv
// Result FIFO with output credit counter and input credit return
`timescale 1ns/1ps

module rda_result_buffer (
	input  logic              clk,
	input  logic              rst,
	input  rda_pkg::add_rsp_t push_data,
	input  logic              push,
	output rda_pkg::add_rsp_t rsp,
	output logic              rsp_valid,
	input  logic              rsp_credit,
	output logic              req_credit
);
	import rda_pkg::*;

	add_rsp_t                mem [RESULT_DEPTH];
	logic [PTR_WIDTH-1:0]    wr_ptr;
	logic [PTR_WIDTH-1:0]    rd_ptr;
	logic [COUNT_WIDTH-1:0]  count;
	logic [CREDIT_WIDTH-1:0] credits;
	logic                    pop;

	function automatic logic [PTR_WIDTH-1:0] ptr_next(logic [PTR_WIDTH-1:0] ptr);
		logic [PTR_WIDTH-1:0] nxt;
		if (ptr == PTR_WIDTH'(RESULT_DEPTH - 1))
			nxt = '0;
		else
			nxt = ptr + 1'b1;
		return nxt;
	endfunction

	// Send whenever a result waits and the consumer has granted room
	assign pop = (count != '0) && (credits != '0);
	assign rsp_valid = pop;
	assign rsp = mem[rd_ptr];

	// Each result leaving frees one slot for the producer
	assign req_credit = pop;

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Output credits granted and spent in the same cycle cancel out
	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= CREDIT_WIDTH'(OUT_CREDIT_INIT);
		end else begin
			case ({rsp_credit, pop})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// Producer credits must keep the buffer from overflowing
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		push |-> (count != COUNT_WIDTH'(RESULT_DEPTH)))
		else $error("push into a full result buffer");

	// Consumer never returns more than it was given
	a_credit_bound: assert property (@(posedge clk) disable iff (rst)
		credits <= CREDIT_WIDTH'(OUT_CREDIT_INIT))
		else $error("output credit count above its initial value");

endmodule

// File: design/rda_top.sv
// Adder top with the pipelined core feeding the credit-controlled result buffer
`timescale 1ns/1ps

module rda_top (
	input  logic              clk,
	input  logic              rst,
	input  rda_pkg::add_req_t req,
	input  logic              req_valid,
	output logic              req_credit,
	output rda_pkg::add_rsp_t rsp,
	output logic              rsp_valid,
	input  logic              rsp_credit
);
	import rda_pkg::*;

	add_rsp_t core_rsp;
	logic     core_valid;

	rda_core u_core (
		.clk       (clk),
		.rst       (rst),
		.req       (req),
		.req_valid (req_valid),
		.rsp       (core_rsp),
		.rsp_valid (core_valid)
	);

	// Buffer room is guaranteed by the producer credits
	rda_result_buffer u_buffer (
		.clk        (clk),
		.rst        (rst),
		.push_data  (core_rsp),
		.push       (core_valid),
		.rsp        (rsp),
		.rsp_valid  (rsp_valid),
		.rsp_credit (rsp_credit),
		.req_credit (req_credit)
	);

endmodule

// File: project.f
design/rda_pkg.sv
design/rda_prefix_stage.sv
design/rda_core.sv
design/rda_result_buffer.sv
design/rda_top.sv
tb/rda_checker.sv
tb/tb_rda.sv

// File: tb/rda_checker.sv
// Result checker predicting sums from accepted requests and comparing them in order
`timescale 1ns/1ps

module rda_checker (
	input  logic                          clk,
	input  logic                          rst,
	input  rda_pkg::add_req_t             req,
	input  logic                          req_valid,
	input  logic [rda_pkg::SUM_WIDTH-1:0] exp_sum,
	input  logic                          exp_check,
	input  rda_pkg::add_rsp_t             rsp,
	input  logic                          rsp_valid,
	input  logic                          rsp_credit,
	input  logic                          req_credit,
	output int                            mismatch_errors,
	output int                            protocol_errors,
	output int                            rsp_count,
	output int                            credit_count,
	output int                            pending
);
	import rda_pkg::*;

	logic [SUM_WIDTH-1:0] expect_q [$];
	logic [SUM_WIDTH-1:0] pred;
	logic [SUM_WIDTH-1:0] head;
	int                   dut_credits;
	logic                 rst_q = 1'b1;

	// Sampled mid-cycle, where every input and output is settled
	always @(negedge clk) begin
		if (rst) begin
			expect_q.delete();
			dut_credits = OUT_CREDIT_INIT;
			mismatch_errors = 0;
			protocol_errors = 0;
			rsp_count = 0;
			credit_count = 0;
		end else begin
			if (rst_q && (rsp_valid !== 1'b0 || req_credit !== 1'b0)) begin
				$display("Error: rsp_valid or req_credit not low right after reset");
				protocol_errors++;
			end
			if (req_valid) begin
				pred = SUM_WIDTH'(req.a) + SUM_WIDTH'(req.b) + SUM_WIDTH'(req.cin);
				if (exp_check && pred !== exp_sum) begin
					$display("Mismatch expected_sum: table 0x%h, predicted 0x%h", exp_sum, pred);
					mismatch_errors++;
				end
				expect_q.push_back(pred);
			end
			if (req_credit !== rsp_valid) begin
				$display("Error: req_credit does not pulse together with rsp_valid");
				protocol_errors++;
			end
			if (rsp_valid) begin
				if (dut_credits <= 0) begin
					$display("Error: result sent while the DUT held no output credit");
					protocol_errors++;
				end
				if (expect_q.size() == 0) begin
					$display("Error: result sent with no request outstanding");
					protocol_errors++;
				end else begin
					head = expect_q.pop_front();
					if (rsp.sum !== head) begin
						$display("Mismatch rsp.sum: got 0x%h, expected 0x%h", rsp.sum, head);
						mismatch_errors++;
					end
				end
				rsp_count++;
			end
			if (req_credit)
				credit_count++;
			// Grant and spend in one cycle cancel out
			dut_credits = dut_credits + int'(rsp_credit) - int'(rsp_valid);
		end
		pending = expect_q.size();
		rst_q = rst;
	end

endmodule

// File: tb/tb_rda.sv
// Testbench for the recursive doubling adder with credit models on both sides
`timescale 1ns/1ps

module tb_rda;
	import rda_pkg::*;

	localparam int TABLE_ROWS = 11;
	localparam int RANDOM_ROWS = 48;
	localparam int TIMEOUT_CYCLES = (TABLE_ROWS + RANDOM_ROWS) * 40 + 200;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] a;
		logic [DATA_WIDTH-1:0] b;
		logic                  cin;
		logic [SUM_WIDTH-1:0]  sum;
		logic                  hold;
	} row_t;

	logic                 clk;
	logic                 rst;
	add_req_t             req;
	logic                 req_valid;
	logic                 req_credit;
	add_rsp_t             rsp;
	logic                 rsp_valid;
	logic                 rsp_credit;
	logic [SUM_WIDTH-1:0] exp_sum;
	logic                 exp_check;

	row_t table_rows [TABLE_ROWS];
	int   sent_count;
	int   credits_back;
	int   owed;
	int   hold_cycles;
	int   end_errors;
	int   mismatch_errors;
	int   protocol_errors;
	int   rsp_count;
	int   credit_count;
	int   pending;

	rda_top UUT (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.req_valid  (req_valid),
		.req_credit (req_credit),
		.rsp        (rsp),
		.rsp_valid  (rsp_valid),
		.rsp_credit (rsp_credit)
	);

	rda_checker u_checker (
		.clk             (clk),
		.rst             (rst),
		.req             (req),
		.req_valid       (req_valid),
		.exp_sum         (exp_sum),
		.exp_check       (exp_check),
		.rsp             (rsp),
		.rsp_valid       (rsp_valid),
		.rsp_credit      (rsp_credit),
		.req_credit      (req_credit),
		.mismatch_errors (mismatch_errors),
		.protocol_errors (protocol_errors),
		.rsp_count       (rsp_count),
		.credit_count    (credit_count),
		.pending         (pending)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Corner sums with hand-worked expected values
	task automatic load_table();
		table_rows[0] = '{64'h0, 64'h0, 1'b0, 65'h0, 1'b0};
		table_rows[1] = '{64'hFFFF_FFFF_FFFF_FFFF, 64'h1, 1'b0, 65'h1_0000_0000_0000_0000, 1'b1};
		table_rows[2] = '{64'hFFFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF, 1'b1,
			65'h1_FFFF_FFFF_FFFF_FFFF, 1'b0};
		table_rows[3] = '{64'hAAAA_AAAA_AAAA_AAAA, 64'h5555_5555_5555_5555, 1'b0,
			65'h0_FFFF_FFFF_FFFF_FFFF, 1'b0};
		table_rows[4] = '{64'hAAAA_AAAA_AAAA_AAAA, 64'h5555_5555_5555_5555, 1'b1,
			65'h1_0000_0000_0000_0000, 1'b0};
		table_rows[5] = '{64'hAAAA_AAAA_AAAA_AAAA, 64'hAAAA_AAAA_AAAA_AAAA, 1'b0,
			65'h1_5555_5555_5555_5554, 1'b0};
		table_rows[6] = '{64'h5555_5555_5555_5555, 64'h5555_5555_5555_5555, 1'b1,
			65'h0_AAAA_AAAA_AAAA_AAAB, 1'b0};
		table_rows[7] = '{64'h0, 64'h0, 1'b1, 65'h1, 1'b0};
		table_rows[8] = '{64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 1'b0,
			65'h1_0000_0000_0000_0000, 1'b1};
		table_rows[9] = '{64'h0123_4567_89AB_CDEF, 64'hFEDC_BA98_7654_3210, 1'b0,
			65'h0_FFFF_FFFF_FFFF_FFFF, 1'b0};
		table_rows[10] = '{64'h7FFF_FFFF_FFFF_FFFF, 64'h1, 1'b0, 65'h0_8000_0000_0000_0000, 1'b0};
	endtask

	// Waits for a producer credit, then holds the request for one edge
	task automatic send_req(input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b,
		input logic cin, input logic [SUM_WIDTH-1:0] sum, input logic check);
		while (RESULT_DEPTH + credits_back - sent_count <= 0) begin
			@(posedge clk);
			#2;
		end
		req.a = a;
		req.b = b;
		req.cin = cin;
		exp_sum = sum;
		exp_check = check;
		req_valid = 1'b1;
		sent_count++;
		@(posedge clk);
		#2;
		req_valid = 1'b0;
		exp_check = 1'b0;
	endtask

	always @(negedge clk) begin
		if (rst)
			credits_back = 0;
		else if (req_credit)
			credits_back++;
	end

	// Consumer returns one credit per result, unless it is holding them back
	initial begin
		logic give;
		rsp_credit = 1'b0;
		owed = 0;
		forever begin
			@(negedge clk);
			if (rst)
				owed = 0;
			else if (rsp_valid)
				owed++;
			give = (owed > 0) && (hold_cycles == 0);
			if (hold_cycles > 0)
				hold_cycles--;
			if (give)
				owed--;
			@(posedge clk);
			#2;
			rsp_credit = give;
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		logic [DATA_WIDTH-1:0] ra;
		logic [DATA_WIDTH-1:0] rb;
		logic [31:0]           rnd;
		int                    total_errors;
		rst = 1'b1;
		req = '0;
		req_valid = 1'b0;
		exp_sum = '0;
		exp_check = 1'b0;
		sent_count = 0;
		hold_cycles = 0;
		end_errors = 0;
		void'($urandom(32'h2d0e_9479));
		load_table();
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;

		for (int i = 0; i < TABLE_ROWS; i++) begin
			if (table_rows[i].hold)
				hold_cycles = 60;
			send_req(table_rows[i].a, table_rows[i].b, table_rows[i].cin,
				table_rows[i].sum, 1'b1);
		end

		for (int i = 0; i < RANDOM_ROWS; i++) begin
			ra = {$urandom, $urandom};
			rb = {$urandom, $urandom};
			rnd = $urandom;
			if (rnd[7:5] == 3'd0)
				hold_cycles = 30;
			send_req(ra, rb, rnd[0], '0, 1'b0);
		end

		wait (rsp_count == sent_count);
		repeat (2) @(posedge clk);
		if (pending != 0) begin
			$display("Error: %0d predictions still waiting for a result", pending);
			end_errors++;
		end
		if (credit_count != sent_count) begin
			$display("Error: %0d req_credit pulses for %0d requests sent",
				credit_count, sent_count);
			end_errors++;
		end

		total_errors = mismatch_errors + protocol_errors + end_errors;
		$display("Error counts: %0d mismatch, %0d protocol, %0d end of run",
			mismatch_errors, protocol_errors, end_errors);
		if (total_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
